// File: bench/fp_ref_model.svh
`ifndef FP_REF_MODEL_SVH
`define FP_REF_MODEL_SVH

// One-hot fclass mask with -inf in bit 0 and qNaN in bit 9
function automatic logic [9:0] ref_class(input logic [31:0] v);
    logic [7:0]  e;
    logic [22:0] m;
    int          idx;
    e = v[30:23];
    m = v[22:0];
    if (e == 8'hff) begin
        if (m == '0) idx = v[31] ? 0 : 7;           // Infinity
        else         idx = m[22] ? 9 : 8;           // Quiet or signaling NaN
    end else if (e == 8'h00) begin
        if (m == '0) idx = v[31] ? 3 : 4;           // Signed zero
        else         idx = v[31] ? 2 : 5;           // Subnormal
    end else begin
        idx = v[31] ? 1 : 6;
    end
    return 10'b1 << idx;
endfunction

// Unsigned key that sorts like the float value with -0 just below +0
function automatic logic [31:0] order_key(input logic [31:0] v);
    return v[31] ? ~v : {1'b1, v[30:0]};
endfunction

function automatic logic [31:0] sign_inject(input logic [31:0] a, input logic [31:0] b,
                                            input rm_t rm);
    case (rm)
        3'd0:    return {b[31], a[30:0]};
        3'd1:    return {~b[31], a[30:0]};
        3'd2:    return {a[31] ^ b[31], a[30:0]};
        default: return a;                          // Move or spare code
    endcase
endfunction

// Expected result and status for one processor request
function automatic void expect_result(input fu_op_e op, input logic [31:0] a,
                                      input logic [31:0] b, input rm_t rm,
                                      output logic [31:0] res, output logic [4:0] status);
    logic [9:0] ca, cb;
    logic       a_nan, b_nan, any_nan, snan, zeros, lt, eq, nv;
    ca      = ref_class(a);
    cb      = ref_class(b);
    a_nan   = ca[9] | ca[8];
    b_nan   = cb[9] | cb[8];
    any_nan = a_nan | b_nan;
    snan    = ca[8] | cb[8];
    zeros   = (a[30:0] == '0) && (b[30:0] == '0);
    lt      = !zeros && (order_key(a) < order_key(b)); // IEEE order treats zeros as equal
    eq      = zeros || (a == b);
    nv      = 1'b0;
    case (op)
        FMIN_MAX: begin
            nv = snan;
            if (a_nan && b_nan)   res = CANONICAL_NAN;
            else if (a_nan)       res = b;
            else if (b_nan)       res = a;
            else if (rm[1:0] == 2'd1) res = (order_key(a) > order_key(b)) ? a : b;
            else                  res = (order_key(a) < order_key(b)) ? a : b;
        end
        FCMP: begin
            res = '0;
            case (rm[1:0])
                2'd0: begin                         // fle
                    res[0] = !any_nan && (lt || eq);
                    nv     = any_nan;
                end
                2'd1: begin                         // flt
                    res[0] = !any_nan && lt;
                    nv     = any_nan;
                end
                2'd2: begin                         // feq
                    res[0] = !any_nan && eq;
                    nv     = snan;
                end
                default: ;
            endcase
        end
        FCLASS:            res = {22'b0, ca};
        FMV_F2X, FMV_X2F:  res = a;
        FSGNJ:             res = sign_inject(a, b, {1'b0, rm[1:0]});
        default:           res = sign_inject(a, b, rm); // Unknown code keeps the raw rm
    endcase
    status         = '0;
    status[NV_BIT] = nv;
endfunction

`endif

// File: bench/tb_fpu_wrap.sv
`timescale 1ns/10ps

module tb_fpu_wrap;

    import fpu_pkg::*;

    `include "fp_ref_model.svh"

    localparam logic [31:0] SEED           = 32'h82fa;
    localparam int unsigned TIMEOUT_CYCLES = 3000; // Ten times what about 130 requests need
    localparam logic [1:0]  SINK_READY     = 2'd0; // Consumer takes every result
    localparam logic [1:0]  SINK_HOLD      = 2'd1;
    localparam logic [1:0]  SINK_RANDOM    = 2'd2; // Ready about one cycle in four

    // FP32 test values
    localparam logic [31:0] P_ONE  = 32'h3f80_0000;
    localparam logic [31:0] P_TWO  = 32'h4000_0000;
    localparam logic [31:0] N_ONE  = 32'hbf80_0000;
    localparam logic [31:0] N_TWO  = 32'hc000_0000;
    localparam logic [31:0] P_ZERO = 32'h0000_0000;
    localparam logic [31:0] N_ZERO = 32'h8000_0000;
    localparam logic [31:0] QNAN   = 32'h7fc0_0000;
    localparam logic [31:0] QNAN_N = 32'hffc0_0001;
    localparam logic [31:0] SNAN   = 32'h7f80_0001;

    logic                   clk_i = 1'b0;
    logic                   rst_ni;
    logic                   flush_i;
    logic                   fpu_valid_i;
    logic                   fpu_ready_o;
    fu_op_e                 operation_i;
    logic [FLEN-1:0]        operand_a_i;
    logic [FLEN-1:0]        operand_b_i;
    rm_t                    rm_i;
    trans_id_t              trans_id_i;
    logic [FLEN-1:0]        result_o;
    trans_id_t              trans_id_o;
    logic [STATUS_BITS-1:0] status_o;
    logic                   result_valid_o;
    logic                   result_ready_i = 1'b1;

    // Expected results in issue order
    logic [FLEN-1:0]        exp_res_q[$];
    trans_id_t              exp_tag_q[$];
    logic [STATUS_BITS-1:0] exp_status_q[$];

    trans_id_t              next_id       = '0;
    logic [1:0]             sink_mode     = SINK_READY;
    int unsigned            cycle         = 0;
    int unsigned            ready_drops   = 0;
    int unsigned            mismatches    = 0; // Wrong output values
    int unsigned            protocol_errs = 0; // Lost, extra or unstable results
    int unsigned            test_errs     = 0; // Latency and flush failures
    logic                   stall_q       = 1'b0;
    logic [FLEN-1:0]        held_res;
    trans_id_t              held_tag;
    logic [STATUS_BITS-1:0] held_status;

    always #5 clk_i = ~clk_i;

    fpu_wrap u_dut (.*);

    //------------------------------------------------------------
    // Consumer, watchdog and output monitor
    //------------------------------------------------------------
    always @(posedge clk_i) begin : consumer
        case (sink_mode)
            SINK_HOLD:   result_ready_i <= 1'b0;
            SINK_RANDOM: result_ready_i <= ($urandom_range(3) == 0);
            default:     result_ready_i <= 1'b1;
        endcase
    end

    always @(posedge clk_i) begin : watchdog
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d results still outstanding",
                     cycle, exp_res_q.size());
            $display("Errors: %0d mismatches, %0d protocol, %0d test",
                     mismatches, protocol_errs, test_errs);
            $display("Simulation FAILED");
            $finish;
        end
    end

    function automatic void check_output();
        logic [FLEN-1:0]        res;
        trans_id_t              tag;
        logic [STATUS_BITS-1:0] status;
        res    = exp_res_q.pop_front();
        tag    = exp_tag_q.pop_front();
        status = exp_status_q.pop_front();
        if (trans_id_o !== tag) begin
            mismatches++;
            $display("CHECK FAILED trans_id_o: got %h expected %h", trans_id_o, tag);
        end
        if (result_o !== res) begin
            mismatches++;
            $display("CHECK FAILED result_o: got %h expected %h (tag %h)", result_o, res, tag);
        end
        if (status_o !== status) begin
            mismatches++;
            $display("CHECK FAILED status_o: got %h expected %h (tag %h)", status_o, status, tag);
        end
    endfunction

    always @(posedge clk_i) begin : monitor
        if (rst_ni) begin
            // A stalled result must wait unchanged
            if (stall_q && (!result_valid_o || result_o !== held_res ||
                            trans_id_o !== held_tag || status_o !== held_status)) begin
                protocol_errs++;
                $display("Output changed while result_valid_o was high and result_ready_i low");
            end
            if (result_valid_o && result_ready_i) begin
                if (exp_res_q.size() == 0) begin
                    protocol_errs++;
                    $display("Extra result with trans_id_o %h, nothing was outstanding",
                             trans_id_o);
                end else begin
                    check_output();
                end
            end
            if (fpu_valid_i && !fpu_ready_o) ready_drops++;
            stall_q     = result_valid_o && !result_ready_i && !flush_i;
            held_res    = result_o;
            held_tag    = trans_id_o;
            held_status = status_o;
            if (flush_i) begin                          // In-flight results are dropped
                exp_res_q.delete();
                exp_tag_q.delete();
                exp_status_q.delete();
            end
        end
    end

    //------------------------------------------------------------
    // Driver tasks
    //------------------------------------------------------------
    // Drives one request onto the inputs without waiting for its transfer
    task automatic present(input fu_op_e op, input logic [31:0] a, input logic [31:0] b,
                           input rm_t rm);
        fpu_valid_i <= 1'b1;
        operation_i <= op;
        operand_a_i <= a;
        operand_b_i <= b;
        rm_i        <= rm;
        trans_id_i  <= next_id;
    endtask

    // Presents one request and returns on the edge it transfers
    task automatic issue(input fu_op_e op, input logic [31:0] a, input logic [31:0] b,
                         input rm_t rm);
        logic [FLEN-1:0]        res;
        logic [STATUS_BITS-1:0] status;
        present(op, a, b, rm);
        do begin
            @(posedge clk_i);
        end while (!fpu_ready_o);
        expect_result(op, a, b, rm, res, status);
        exp_res_q.push_back(res);
        exp_tag_q.push_back(next_id);
        exp_status_q.push_back(status);
        next_id = next_id + 1'b1;
    endtask

    task automatic stop_issue();
        fpu_valid_i <= 1'b0;
    endtask

    // Waits until every expected result has left
    task automatic drain();
        stop_issue();
        while (exp_res_q.size() != 0) @(negedge clk_i);
        @(posedge clk_i);
    endtask

    //------------------------------------------------------------
    // Directed tests
    //------------------------------------------------------------
    task automatic sign_inject_and_moves();
        logic [31:0] a, b;
        for (int i = 0; i < 8; i++) begin
            a = $urandom();
            b = $urandom();
            for (int r = 0; r < 4; r++) issue(FSGNJ, a, b, rm_t'(r));
            issue(FMV_F2X, a, b, 3'd6);
            issue(FMV_X2F, a, b, 3'd1);
            issue(fu_op_e'(4'd9), a, b, rm_t'(i));  // Unknown code
        end
        issue(FSGNJ, P_ZERO, N_ZERO, RM_SGNJ);
        issue(FSGNJ, N_ZERO, N_ZERO, RM_SGNJX);
        issue(FSGNJ, N_ZERO, P_ZERO, RM_SGNJN);
        drain();
    endtask

    task automatic min_max_nan_rules();
        logic [31:0] va[9];
        logic [31:0] vb[9];
        va = '{P_ONE, N_ONE, P_ZERO, N_ZERO, QNAN, P_ONE, QNAN, SNAN, P_TWO};
        vb = '{P_TWO, N_TWO, N_ZERO, P_ZERO, P_ONE, QNAN_N, QNAN_N, P_ONE, SNAN};
        for (int i = 0; i < 9; i++) begin
            issue(FMIN_MAX, va[i], vb[i], RM_MIN);
            issue(FMIN_MAX, va[i], vb[i], RM_MAX);
        end
        drain();
    endtask

    task automatic compare_pairs();
        logic [31:0] va[7];
        logic [31:0] vb[7];
        va = '{P_ONE, P_ONE, P_TWO, P_ZERO, QNAN, P_ONE, N_TWO};
        vb = '{P_ONE, P_TWO, P_ONE, N_ZERO, P_ONE, SNAN, N_ONE};
        for (int i = 0; i < 7; i++) begin
            issue(FCMP, va[i], vb[i], RM_FEQ);
            issue(FCMP, va[i], vb[i], RM_FLT);
            issue(FCMP, va[i], vb[i], RM_FLE);
        end
        drain();
    endtask

    task automatic classify_each_class();
        logic [31:0] v[10];
        v = '{32'hff80_0000, N_ONE, 32'h8000_0001, N_ZERO, P_ZERO,
              32'h0000_0001, P_TWO, 32'h7f80_0000, SNAN, QNAN};   // One per class
        for (int i = 0; i < 10; i++) issue(FCLASS, v[i], $urandom(), rm_t'(i));
        drain();
    endtask

    task automatic back_pressure_order();
        int unsigned drops_before;
        drops_before = ready_drops;
        sink_mode   <= SINK_HOLD;
        issue(FSGNJ, $urandom(), $urandom(), RM_SGNJN);
        issue(FSGNJ, $urandom(), $urandom(), RM_SGNJX);
        sink_mode   <= SINK_RANDOM;                    // Third request meets a full pipe
        for (int i = 0; i < 14; i++) issue(FSGNJ, $urandom(), $urandom(), rm_t'(i % 4));
        sink_mode   <= SINK_READY;
        drain();
        if (ready_drops == drops_before) begin
            test_errs++;
            $display("fpu_ready_o never dropped while results were held back");
        end
    endtask

    task automatic latency_then_flush();
        int unsigned start;
        issue(FCLASS, P_ONE, P_ZERO, RM_FLE);
        start = cycle;
        stop_issue();
        do begin
            @(posedge clk_i);
        end while (!result_valid_o);
        if (cycle - start != 2) begin
            test_errs++;
            $display("Result came %0d cycles after its transfer instead of 2", cycle - start);
        end
        // Fill both stages and park a third request in the hold register
        sink_mode <= SINK_HOLD;
        issue(FSGNJ, $urandom(), $urandom(), RM_SGNJ);
        issue(FMIN_MAX, P_ONE, N_ONE, RM_MAX);
        present(FCLASS, QNAN, P_ONE, RM_FLE);
        @(posedge clk_i);
        if (fpu_ready_o) begin
            test_errs++;
            $display("fpu_ready_o stayed high with both stages full");
        end
        stop_issue();
        flush_i   <= 1'b1;
        @(posedge clk_i);
        flush_i   <= 1'b0;
        sink_mode <= SINK_READY;
        repeat (6) begin
            @(posedge clk_i);
            if (result_valid_o || !fpu_ready_o) begin
                test_errs++;
                $display("After flush a result was still valid or the FPU was not ready");
            end
        end
    endtask

    initial begin : main
        void'($urandom(SEED));
        rst_ni      <= 1'b0;
        flush_i     <= 1'b0;
        fpu_valid_i <= 1'b0;
        operation_i <= FSGNJ;
        operand_a_i <= '0;
        operand_b_i <= '0;
        rm_i        <= '0;
        trans_id_i  <= '0;
        repeat (4) @(posedge clk_i);
        rst_ni      <= 1'b1;
        @(posedge clk_i);
        sign_inject_and_moves();
        min_max_nan_rules();
        compare_pairs();
        classify_each_class();
        back_pressure_order();
        latency_then_flush();
        if (exp_res_q.size() != 0) begin
            protocol_errs++;
            $display("%0d expected results never appeared", exp_res_q.size());
        end
        $display("Errors: %0d mismatches, %0d protocol, %0d test",
                 mismatches, protocol_errs, test_errs);
        if (mismatches + protocol_errs + test_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/fp_decoder.sv
`timescale 1ns/10ps

module fp_decoder (
    input  fpu_pkg::fu_op_e          operation_i,
    input  fpu_pkg::rm_t             rm_i,
    input  logic [fpu_pkg::FLEN-1:0] operand_a_i,
    input  logic [fpu_pkg::FLEN-1:0] operand_b_i,
    input  fpu_pkg::trans_id_t       trans_id_i,
    output fpu_pkg::issue_req_t      req_o
);

    import fpu_pkg::*;

    rm_t rm_masked; // rm without the MSB, which this unit never uses

    assign rm_masked = {1'b0, rm_i[1:0]};

    //------------------------------------------------------------
    // Operation translation
    //------------------------------------------------------------
    always_comb begin : op_translation
        // Operands and tag pass straight through
        req_o.operand_a = operand_a_i;
        req_o.operand_b = operand_b_i;
        req_o.tag       = trans_id_i;

        // Sign injection with raw rm unless a known op says otherwise
        req_o.unit_op = UOP_SGNJ;
        req_o.rm      = rm_i;

        case (operation_i)
            // sgnj, sgnjn, sgnjx selected by rm
            FSGNJ: begin
                req_o.unit_op = UOP_SGNJ;
                req_o.rm      = rm_masked;
            end
            // min or max selected by rm
            FMIN_MAX: begin
                req_o.unit_op = UOP_MINMAX;
                req_o.rm      = rm_masked;
            end
            // fle, flt, feq selected by rm
            FCMP: begin
                req_o.unit_op = UOP_CMP;
                req_o.rm      = rm_masked;
            end
            // Classify ignores rm anyway
            FCLASS: begin
                req_o.unit_op = UOP_CLASSIFY;
                req_o.rm      = rm_masked;
            end
            // FPR to GPR move, no recoding needed
            FMV_F2X: begin
                req_o.unit_op = UOP_SGNJ;
                req_o.rm      = RM_PASS;
            end
            // GPR to FPR move, same passthrough
            FMV_X2F: begin
                req_o.unit_op = UOP_SGNJ;
                req_o.rm      = RM_PASS;
            end
            default: begin
                // Unknown code, keep sign injection defaults
                req_o.unit_op = UOP_SGNJ;
                req_o.rm      = rm_i;
            end
        endcase
    end

endmodule

// File: rtl/fp_issue_buffer.sv
`timescale 1ns/10ps

module fp_issue_buffer (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic                valid_i,      // Upstream request valid
    output logic                ready_o,      // Upstream may issue
    input  fpu_pkg::issue_req_t req_i,        // Decoded live request
    output logic                out_valid_o,  // Request toward the unit
    input  logic                out_ready_i,  // Unit takes the request
    output fpu_pkg::issue_req_t req_o         // Held or live request
);

    import fpu_pkg::*;

    typedef enum logic {READY, STALL} state_e;

    state_e     state_q, state_d;
    issue_req_t hold_q;       // Parked request
    logic       hold_inputs;  // Capture live request this cycle
    logic       use_hold;     // Feed unit from the hold register

    //------------------------------------------------------------
    // Protocol inversion FSM
    //------------------------------------------------------------
    // Upstream sees ready before the unit has answered, so a refused
    // request is parked and upstream is stalled until it drains
    always_comb begin : p_issue_fsm
        ready_o     = 1'b0;
        out_valid_o = 1'b0;
        hold_inputs = 1'b0;
        use_hold    = 1'b0;
        state_d     = state_q;

        case (state_q)
            READY: begin
                ready_o     = 1'b1;     // Accept as if unit ready
                out_valid_o = valid_i;  // Live forward
                if (valid_i && !out_ready_i) begin
                    ready_o     = 1'b0; // Upstream keeps presenting the request
                    hold_inputs = 1'b1; // Park it here meanwhile
                    state_d     = STALL;
                end
            end
            STALL: begin
                out_valid_o = 1'b1;     // Held request pending
                use_hold    = 1'b1;
                if (out_ready_i) begin
                    ready_o = 1'b1;     // Held request drains and upstream moves on
                    state_d = READY;
                end
            end
            default: state_d = READY;
        endcase

        // Flush drops the parked request
        if (flush_i) begin
            state_d = READY;
        end
    end

    // FSM state
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    // Hold register loaded only on a refused request
    always_ff @(posedge clk_i) begin : p_hold_reg
        if (hold_inputs) begin
            hold_q <= req_i;
        end
    end

    assign req_o = use_hold ? hold_q : req_i; // Output mux

endmodule

// File: rtl/fp_noncomp_unit.sv
`timescale 1ns/10ps

module fp_noncomp_unit (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            flush_i,
    input  logic                            in_valid_i,
    output logic                            in_ready_o,
    input  fpu_pkg::issue_req_t             req_i,
    output logic [fpu_pkg::FLEN-1:0]        result_o,
    output fpu_pkg::trans_id_t              tag_o,
    output logic [fpu_pkg::STATUS_BITS-1:0] status_o,
    output logic                            out_valid_o,
    input  logic                            out_ready_i
);

    import fpu_pkg::*;

    // Maps one FP32 value onto its fclass one-hot mask
    function automatic logic [CLASS_BITS-1:0] classify(input logic [FLEN-1:0] v);
        logic                  sign;
        logic                  exp_ones;
        logic                  exp_zero;
        logic                  man_zero;
        logic [CLASS_BITS-1:0] mask;
        sign     = v[SIGN_BIT];
        exp_ones = &v[MAN_BITS +: EXP_BITS];
        exp_zero = ~|v[MAN_BITS +: EXP_BITS];
        man_zero = ~|v[MAN_BITS-1:0];
        mask     = '0;
        if (exp_ones && !man_zero) begin
            mask[v[MAN_BITS-1] ? 9 : 8] = 1'b1;      // Quiet bit is the mantissa MSB
        end else if (exp_ones) begin
            mask[sign ? 0 : 7] = 1'b1;               // Infinity
        end else if (exp_zero && man_zero) begin
            mask[sign ? 3 : 4] = 1'b1;               // Zero
        end else if (exp_zero) begin
            mask[sign ? 2 : 5] = 1'b1;               // Subnormal
        end else begin
            mask[sign ? 1 : 6] = 1'b1;               // Normal
        end
        return mask;
    endfunction

    //------------------------------------------------------------
    // Operand analysis
    //------------------------------------------------------------
    logic [FLEN-1:0]       op_a, op_b;
    logic [CLASS_BITS-1:0] class_a, class_b;
    logic                  any_nan, both_nan, any_snan;
    logic                  both_zero;
    logic                  ord_lt;  // Total order, -0 below +0
    logic                  cmp_lt, cmp_eq;

    assign op_a    = req_i.operand_a;
    assign op_b    = req_i.operand_b;
    assign class_a = classify(op_a);
    assign class_b = classify(op_b);

    assign any_nan   = |{class_a[9:8], class_b[9:8]};
    assign both_nan  = (|class_a[9:8]) && (|class_b[9:8]);
    assign any_snan  = class_a[8] | class_b[8];
    assign both_zero = (|class_a[4:3]) && (|class_b[4:3]);

    // Sign-magnitude ordering
    assign ord_lt = (op_a[SIGN_BIT] != op_b[SIGN_BIT]) ? op_a[SIGN_BIT] :
                    op_a[SIGN_BIT] ? (op_a[FLEN-2:0] > op_b[FLEN-2:0]) :
                                     (op_a[FLEN-2:0] < op_b[FLEN-2:0]);
    assign cmp_lt = ord_lt && !both_zero;            // IEEE compare, zeros equal
    assign cmp_eq = (op_a == op_b) || both_zero;

    //------------------------------------------------------------
    // Result selection
    //------------------------------------------------------------
    logic [FLEN-1:0] res_d;
    logic            nv_d;

    always_comb begin : p_compute
        res_d = op_a;
        nv_d  = 1'b0;
        case (req_i.unit_op)
            UOP_SGNJ: begin
                case (req_i.rm)
                    RM_SGNJ:  res_d = {op_b[SIGN_BIT], op_a[FLEN-2:0]};
                    RM_SGNJN: res_d = {~op_b[SIGN_BIT], op_a[FLEN-2:0]};
                    RM_SGNJX: res_d = {op_a[SIGN_BIT] ^ op_b[SIGN_BIT], op_a[FLEN-2:0]};
                    default:  res_d = op_a;          // RM_PASS and spare codes
                endcase
            end
            UOP_MINMAX: begin
                nv_d = any_snan;
                if (both_nan) begin
                    res_d = CANONICAL_NAN;
                end else if (|class_a[9:8]) begin
                    res_d = op_b;                    // NaN operand loses
                end else if (|class_b[9:8]) begin
                    res_d = op_a;
                end else if (req_i.rm == RM_MAX) begin
                    res_d = ord_lt ? op_b : op_a;
                end else begin
                    res_d = ord_lt ? op_a : op_b;
                end
            end
            UOP_CMP: begin
                res_d = '0;
                case (req_i.rm)
                    RM_FLE: begin
                        res_d[0] = !any_nan && (cmp_lt || cmp_eq);
                        nv_d     = any_nan;          // Signaling compare
                    end
                    RM_FLT: begin
                        res_d[0] = !any_nan && cmp_lt;
                        nv_d     = any_nan;
                    end
                    RM_FEQ: begin
                        res_d[0] = !any_nan && cmp_eq;
                        nv_d     = any_snan;         // Quiet compare
                    end
                    default: ;
                endcase
            end
            default: res_d = {{(FLEN-CLASS_BITS){1'b0}}, class_a}; // Classify
        endcase
    end

    //------------------------------------------------------------
    // Two-stage elastic pipeline
    //------------------------------------------------------------
    logic            s1_valid_q, s2_valid_q;
    logic [FLEN-1:0] s1_res_q, s2_res_q;
    logic            s1_nv_q, s2_nv_q;
    trans_id_t       s1_tag_q, s2_tag_q;
    logic            s1_ready, s2_ready;

    assign s2_ready   = !s2_valid_q || out_ready_i;  // Output empty or draining
    assign s1_ready   = !s1_valid_q || s2_ready;
    assign in_ready_o = s1_ready;

    // Valid bits, cleared by flush
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else if (flush_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_ready) s1_valid_q <= in_valid_i;
            if (s2_ready) s2_valid_q <= s1_valid_q;
        end
    end

    // Payload, loaded only with a moving item
    always_ff @(posedge clk_i) begin : p_payload
        if (in_valid_i && s1_ready) begin
            s1_res_q <= res_d;
            s1_nv_q  <= nv_d;
            s1_tag_q <= req_i.tag;
        end
        if (s1_valid_q && s2_ready) begin
            s2_res_q <= s1_res_q;
            s2_nv_q  <= s1_nv_q;
            s2_tag_q <= s1_tag_q;
        end
    end

    assign out_valid_o = s2_valid_q;
    assign result_o    = s2_res_q;
    assign tag_o       = s2_tag_q;

    always_comb begin : p_status
        status_o         = '0;      // Only NV is ever raised
        status_o[NV_BIT] = s2_nv_q;
    end

endmodule

// File: rtl/fpu_pkg.sv
package fpu_pkg;

    //------------------------------------------------------------
    // Widths and constants
    //------------------------------------------------------------
    localparam int unsigned FLEN          = 32; // FP32 operands and results
    localparam int unsigned TRANS_ID_BITS = 3;  // Scoreboard tag width
    localparam int unsigned STATUS_BITS   = 5;  // fflags NV DZ OF UF NX
    localparam int unsigned NV_BIT        = 4;  // Invalid operation flag position
    localparam int unsigned CLASS_BITS    = 10; // RISC-V fclass mask width

    // FP32 field layout
    localparam int unsigned SIGN_BIT = 31;
    localparam int unsigned EXP_BITS = 8;
    localparam int unsigned MAN_BITS = 23;

    localparam logic [FLEN-1:0] CANONICAL_NAN = 32'h7fc0_0000; // Quiet NaN, positive

    //------------------------------------------------------------
    // Operation encodings
    //------------------------------------------------------------
    // Processor side operation, codes beyond FMV_X2F fall back to sign injection
    typedef enum logic [3:0] {
        FSGNJ    = 4'd0,
        FMIN_MAX = 4'd1,
        FCMP     = 4'd2,
        FCLASS   = 4'd3,
        FMV_F2X  = 4'd4,
        FMV_X2F  = 4'd5
    } fu_op_e;

    // Operation as seen by the execution unit
    typedef enum logic [1:0] {
        UOP_SGNJ     = 2'd0,
        UOP_MINMAX   = 2'd1,
        UOP_CMP      = 2'd2,
        UOP_CLASSIFY = 2'd3
    } unit_op_e;

    typedef logic [2:0]               rm_t;       // rm field, reused as sub-mode
    typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

    // Sub-modes carried in rm
    localparam rm_t RM_SGNJ  = 3'd0;
    localparam rm_t RM_SGNJN = 3'd1;
    localparam rm_t RM_SGNJX = 3'd2;
    localparam rm_t RM_PASS  = 3'd3; // Plain move, operand A unchanged
    localparam rm_t RM_MIN   = 3'd0;
    localparam rm_t RM_MAX   = 3'd1;
    localparam rm_t RM_FLE   = 3'd0;
    localparam rm_t RM_FLT   = 3'd1;
    localparam rm_t RM_FEQ   = 3'd2;

    // Decoded request, 72 bits
    typedef struct packed {
        logic [FLEN-1:0] operand_a;
        logic [FLEN-1:0] operand_b;
        unit_op_e        unit_op;
        rm_t             rm;
        trans_id_t       tag;
    } issue_req_t;

endpackage

// File: rtl/fpu_wrap.sv
`timescale 1ns/10ps

module fpu_wrap (
    input  logic                            clk_i,
    input  logic                            rst_ni,
    input  logic                            flush_i,
    input  logic                            fpu_valid_i,
    output logic                            fpu_ready_o,
    input  fpu_pkg::fu_op_e                 operation_i,
    input  logic [fpu_pkg::FLEN-1:0]        operand_a_i,
    input  logic [fpu_pkg::FLEN-1:0]        operand_b_i,
    input  fpu_pkg::rm_t                    rm_i,
    input  fpu_pkg::trans_id_t              trans_id_i,
    output logic [fpu_pkg::FLEN-1:0]        result_o,
    output fpu_pkg::trans_id_t              trans_id_o,
    output logic [fpu_pkg::STATUS_BITS-1:0] status_o,
    output logic                            result_valid_o,
    input  logic                            result_ready_i
);

    import fpu_pkg::*;

    issue_req_t dec_req;        // Decoded live request
    issue_req_t unit_req;       // Request presented to the unit
    logic       unit_in_valid;
    logic       unit_in_ready;

    // Decode, buffer, execute
    fp_decoder u_decoder (
        .operation_i (operation_i),
        .rm_i        (rm_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .trans_id_i  (trans_id_i),
        .req_o       (dec_req)
    );

    fp_issue_buffer u_issue_buffer (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .valid_i     (fpu_valid_i),
        .ready_o     (fpu_ready_o),
        .req_i       (dec_req),
        .out_valid_o (unit_in_valid),
        .out_ready_i (unit_in_ready),
        .req_o       (unit_req)
    );

    fp_noncomp_unit u_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .in_valid_i  (unit_in_valid),
        .in_ready_o  (unit_in_ready),
        .req_i       (unit_req),
        .result_o    (result_o),
        .tag_o       (trans_id_o),
        .status_o    (status_o),
        .out_valid_o (result_valid_o),
        .out_ready_i (result_ready_i)     // Downstream back-pressure
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator and run the testbench; the exit status follows the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_fpu_wrap \
    && ./obj_dir/Vtb_fpu_wrap | tee /dev/stderr | grep -qx "Simulation PASSED" \
    && echo "run_sim: testbench reported success" \
    || { echo "run_sim: build or simulation did not succeed" >&2; exit 1; }

// File: vlog.f
+incdir+bench
rtl/fpu_pkg.sv
rtl/fp_decoder.sv
rtl/fp_issue_buffer.sv
rtl/fp_noncomp_unit.sv
rtl/fpu_wrap.sv
bench/tb_fpu_wrap.sv
